// File: tf_settings.svh
`ifndef TF_SETTINGS_SVH
`define TF_SETTINGS_SVH

// Lanes processed side by side with one multiplier each
`define TF_LANES 4

// One base table row per stage depth
`define TF_DEPTHS 4

// Entries of the step multiplier table
`define TF_CONSTS 8

// Residue word width in bits
`define TF_WIDTH 12

// Modulus q of the transform
`define TF_MODULUS 3329

`define TF_BARRETT_MU 5039 // Floor of 2^(2*TF_WIDTH) / q

// Cycles from multiplier operands to reduced result
`define TF_MULT_LATENCY 3

`endif

// File: tf_arith_pkg.sv
`include "tf_settings.svh"

package tf_arith_pkg;

	// One residue modulo q
	typedef logic [`TF_WIDTH-1:0] tf_word_t;

	typedef logic [2*`TF_WIDTH-1:0] tf_prod_t; // Full product before reduction

	// One word per lane as used for base rows, constant reads and outputs
	typedef tf_word_t [`TF_LANES-1:0] tf_lane_vec_t;

	// The whole constant table as it is loaded
	typedef tf_word_t [`TF_CONSTS-1:0] tf_const_vec_t;

endpackage

// File: tf_ctrl_pkg.sv
`include "tf_settings.svh"

package tf_ctrl_pkg;

	// Command opcodes where op_idle means no command this cycle
	typedef enum logic [1:0] {
		op_idle       = 2'd0,
		op_load_base  = 2'd1,
		op_load_const = 2'd2,
		op_step       = 2'd3
	} tf_op_e;

	typedef logic [$clog2(`TF_DEPTHS)-1:0] tf_depth_t; // Base row index

	typedef logic [$clog2(`TF_CONSTS)-1:0] tf_cidx_t; // Constant table index

	// Each lane names its own constant
	typedef tf_cidx_t [`TF_LANES-1:0] tf_cidx_vec_t;

	// One command as sampled on every rising clock edge
	typedef struct packed {
		tf_op_e       op;
		tf_depth_t    depth;
		tf_cidx_vec_t cidx;
	} tf_cmd_t;

endpackage

// File: barrett_mult.sv
`include "tf_settings.svh"

module barrett_mult (
	input  logic                   clk,
	input  logic                   rst,
	input  tf_arith_pkg::tf_word_t a,
	input  tf_arith_pkg::tf_word_t b,
	output tf_arith_pkg::tf_word_t result
);
	import tf_arith_pkg::*;

	localparam int SHIFT = 2 * `TF_WIDTH;
	localparam int MU_W = $clog2(`TF_BARRETT_MU + 1);
	localparam logic [SHIFT+MU_W-1:0] MU = `TF_BARRETT_MU;
	localparam tf_prod_t Q = `TF_MODULUS;

	tf_prod_t prod_s1;
	tf_prod_t prod_s2;
	tf_word_t quot_s2;
	logic [SHIFT+MU_W-1:0] prod_mu;
	tf_word_t quot_est;
	tf_word_t rem_red;

	// The quotient estimate is at most two below the true quotient
	assign prod_mu = prod_s1 * MU;
	assign quot_est = tf_word_t'(prod_mu >> SHIFT);

	always_comb begin
		tf_prod_t r;
		r = prod_s2 - tf_prod_t'(quot_s2) * Q;
		if (r >= Q)
			r = r - Q;
		if (r >= Q)
			r = r - Q; // Now below q
		rem_red = tf_word_t'(r);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_s1 <= '0;
			prod_s2 <= '0;
			quot_s2 <= '0;
			result <= '0;
		end else begin
			prod_s1 <= tf_prod_t'(a) * tf_prod_t'(b);
			prod_s2 <= prod_s1; // Product travels alongside its estimate
			quot_s2 <= quot_est;
			result <= rem_red;
		end
	end

endmodule

// File: tf_base_bank.sv
`include "tf_settings.svh"

module tf_base_bank (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wr_en,
	input  tf_ctrl_pkg::tf_depth_t     wr_row,
	input  tf_arith_pkg::tf_lane_vec_t wr_data,
	input  logic                       rd_en,
	input  tf_ctrl_pkg::tf_depth_t     rd_row,
	output tf_arith_pkg::tf_lane_vec_t rd_data
);
	import tf_arith_pkg::*;

	tf_lane_vec_t rows [`TF_DEPTHS];

	// A read on the same edge as a write to that row returns the old row
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `TF_DEPTHS; i++) begin
				rows[i] <= '0;
			end
			rd_data <= '0;
		end else begin
			if (wr_en)
				rows[wr_row] <= wr_data;
			if (rd_en)
				rd_data <= rows[rd_row]; // Holds between reads
		end
	end

endmodule

// File: tf_const_bank.sv
`include "tf_settings.svh"

module tf_const_bank (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        load,
	input  tf_arith_pkg::tf_const_vec_t load_data,
	input  logic                        rd_en,
	input  tf_ctrl_pkg::tf_cidx_vec_t   cidx,
	output tf_arith_pkg::tf_lane_vec_t  rd_data
);
	import tf_arith_pkg::*;

	tf_const_vec_t const_tab;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			const_tab <= '0;
			rd_data <= '0;
		end else begin
			if (load)
				const_tab <= load_data; // Whole table in one cycle
			if (rd_en) begin
				// Every lane picks its own entry
				for (int i = 0; i < `TF_LANES; i++) begin
					rd_data[i] <= const_tab[cidx[i]];
				end
			end
		end
	end

endmodule

// File: tf_step_ctrl.sv
`include "tf_settings.svh"

module tf_step_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  tf_ctrl_pkg::tf_cmd_t   cmd,
	output logic                   base_wr_en,
	output tf_ctrl_pkg::tf_depth_t base_wr_row,
	output logic                   base_wr_sel_result,
	output logic                   const_load,
	output logic                   rd_en,
	output logic                   out_valid
);
	import tf_ctrl_pkg::*;

	// One stage for the bank read and one per multiplier stage
	localparam int STAGES = `TF_MULT_LATENCY + 1;

	logic step_cmd;
	logic load_cmd;
	logic [STAGES-1:0] pipe_valid;
	tf_depth_t pipe_depth [STAGES];
	logic retire;

	assign step_cmd = (cmd.op == op_step);
	assign load_cmd = (cmd.op == op_load_base);
	assign const_load = (cmd.op == op_load_const);
	assign rd_en = step_cmd; // Banks register the row on the sampling edge

	// Results of the oldest step sit at the multiplier outputs
	assign retire = pipe_valid[STAGES-1];

	assign out_valid = retire;
	assign base_wr_sel_result = retire;
	assign base_wr_en = retire | load_cmd;
	assign base_wr_row = retire ? pipe_depth[STAGES-1] : cmd.depth;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pipe_valid <= '0;
		else
			pipe_valid <= {pipe_valid[STAGES-2:0], step_cmd};
	end

	// The row of each step in flight is needed again at write-back
	always_ff @(posedge clk) begin
		pipe_depth[0] <= cmd.depth;
		for (int i = 1; i < STAGES; i++) begin
			pipe_depth[i] <= pipe_depth[i-1];
		end
	end

endmodule

// File: tf_gen.sv
`include "tf_settings.svh"

module tf_gen (
	input  logic                        clk,
	input  logic                        rst,
	input  tf_ctrl_pkg::tf_cmd_t        cmd,
	input  tf_arith_pkg::tf_lane_vec_t  base_in,
	input  tf_arith_pkg::tf_const_vec_t const_in,
	output tf_arith_pkg::tf_lane_vec_t  tf_out,
	output logic                        tf_valid
);
	import tf_arith_pkg::*;
	import tf_ctrl_pkg::*;

	logic base_wr_en;
	tf_depth_t base_wr_row;
	logic base_wr_sel_result;
	logic const_load;
	logic rd_en;
	tf_lane_vec_t base_wr_data;
	tf_lane_vec_t base_row;
	tf_lane_vec_t const_row;

	tf_step_ctrl u_ctrl (
		.clk                (clk),
		.rst                (rst),
		.cmd                (cmd),
		.base_wr_en         (base_wr_en),
		.base_wr_row        (base_wr_row),
		.base_wr_sel_result (base_wr_sel_result),
		.const_load         (const_load),
		.rd_en              (rd_en),
		.out_valid          (tf_valid)
	);

	// Write-back of products or an external row load
	assign base_wr_data = base_wr_sel_result ? tf_out : base_in;

	tf_base_bank u_base (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (base_wr_en),
		.wr_row  (base_wr_row),
		.wr_data (base_wr_data),
		.rd_en   (rd_en),
		.rd_row  (cmd.depth),
		.rd_data (base_row)
	);

	tf_const_bank u_const (
		.clk       (clk),
		.rst       (rst),
		.load      (const_load),
		.load_data (const_in),
		.rd_en     (rd_en),
		.cidx      (cmd.cidx),
		.rd_data   (const_row)
	);

	for (genvar g = 0; g < `TF_LANES; g++) begin : g_lane
		barrett_mult u_mult (
			.clk    (clk),
			.rst    (rst),
			.a      (base_row[g]),
			.b      (const_row[g]),
			.result (tf_out[g])
		);
	end

endmodule

// File: tf_gen_tb_assertions.sv
`include "tf_settings.svh"

module tf_gen_tb_assertions (
	input logic                 clk,
	input logic                 rst,
	input tf_ctrl_pkg::tf_cmd_t cmd,
	input logic                 tf_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	import tf_ctrl_pkg::*;

	localparam int STAGES = `TF_MULT_LATENCY + 1;

	logic [STAGES-1:0] hist_valid; // Steps sampled one to four edges ago
	tf_depth_t hist_depth [STAGES];
	logic depth_busy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hist_valid <= '0;
			for (int i = 0; i < STAGES; i++) begin
				hist_depth[i] <= '0;
			end
		end else begin
			hist_valid <= {hist_valid[STAGES-2:0], cmd.op == op_step};
			hist_depth[0] <= cmd.depth;
			for (int i = 1; i < STAGES; i++) begin
				hist_depth[i] <= hist_depth[i-1];
			end
		end
	end

	// A row stays busy up to and including its write-back edge
	always_comb begin
		depth_busy = 1'b0;
		for (int i = 0; i < STAGES; i++) begin
			if (hist_valid[i] && hist_depth[i] == cmd.depth)
				depth_busy = 1'b1;
		end
	end

	load_base_when_idle: assert property (@(posedge clk) disable iff (rst)
		cmd.op == op_load_base |-> hist_valid == '0)
		else $error("base row load issued while a step is in flight");

	step_to_free_depth: assert property (@(posedge clk) disable iff (rst)
		cmd.op == op_step |-> !depth_busy)
		else $error("step issued to a depth that already has a step in flight");

	valid_follows_step: assert property (@(posedge clk) disable iff (rst)
		tf_valid |-> hist_valid[STAGES-1])
		else $error("tf_valid high without a step sampled four cycles earlier");

endmodule

bind tf_gen tf_gen_tb_assertions u_assert (
	.clk      (clk),
	.rst      (rst),
	.cmd      (cmd),
	.tf_valid (tf_valid)
);

// File: tf_gen_tb.sv
`include "tf_settings.svh"

module tf_gen_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import tf_arith_pkg::*;
	import tf_ctrl_pkg::*;

	localparam int STEP_LATENCY = `TF_MULT_LATENCY + 1; // Read cycle plus multiplier
	localparam int VALID_TIMEOUT = 50;

	logic clk;
	logic rst;
	tf_cmd_t cmd;
	tf_lane_vec_t base_in;
	tf_const_vec_t const_in;
	tf_lane_vec_t tf_out;
	logic tf_valid;

	tf_lane_vec_t shadow_base [`TF_DEPTHS]; // Reference copy of the base table
	tf_const_vec_t shadow_const;
	logic [31:0] lfsr_state;

	tf_gen UUT (
		.clk      (clk),
		.rst      (rst),
		.cmd      (cmd),
		.base_in  (base_in),
		.const_in (const_in),
		.tf_out   (tf_out),
		.tf_valid (tf_valid)
	);

	always #2 clk = ~clk;

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic tf_word_t rand_word();
		if (rand_bits(2) == 32'd0)
			return tf_word_t'(`TF_MODULUS - 1 - rand_bits(2)); // Close to the top of the range
		return tf_word_t'(rand_bits(16) % `TF_MODULUS);
	endfunction

	function automatic tf_lane_vec_t rand_row();
		tf_lane_vec_t r;
		for (int i = 0; i < `TF_LANES; i++) begin
			r[i] = rand_word();
		end
		return r;
	endfunction

	function automatic tf_const_vec_t rand_consts();
		tf_const_vec_t r;
		for (int i = 0; i < `TF_CONSTS; i++) begin
			r[i] = rand_word();
		end
		return r;
	endfunction

	function automatic tf_cidx_vec_t rand_cidx();
		tf_cidx_vec_t r;
		for (int i = 0; i < `TF_LANES; i++) begin
			r[i] = tf_cidx_t'(rand_bits($bits(tf_cidx_t)));
		end
		return r;
	endfunction

	function automatic tf_word_t mod_mul(input tf_word_t a, input tf_word_t b);
		int unsigned p;
		p = 32'(a) * 32'(b);
		return tf_word_t'(p % `TF_MODULUS);
	endfunction

	function automatic tf_word_t pow_mod(input tf_word_t c, input int k);
		tf_word_t r;
		r = 12'd1;
		for (int i = 0; i < k; i++) begin
			r = mod_mul(r, c);
		end
		return r;
	endfunction

	// Expected products of one step are also written back into the shadow row
	function automatic tf_lane_vec_t model_step(input tf_depth_t d, input tf_cidx_vec_t ci);
		tf_lane_vec_t r;
		for (int i = 0; i < `TF_LANES; i++) begin
			r[i] = mod_mul(shadow_base[d][i], shadow_const[ci[i]]);
		end
		shadow_base[d] = r;
		return r;
	endfunction

	function automatic tf_cmd_t make_cmd(input tf_op_e op, input tf_depth_t d,
		input tf_cidx_vec_t ci);
		tf_cmd_t c;
		c.op = op;
		c.depth = d;
		c.cidx = ci;
		return c;
	endfunction

	task automatic check_lanes(input tf_lane_vec_t got, input tf_lane_vec_t exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s, tf_out %h, expected %h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s, tf_valid %b, expected %b", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("mismatch at %0t: %s, latency %0d cycles, expected %0d",
				$time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	// Counts falling edges since the first step was driven
	task automatic wait_valid(input int start, output int cycles);
		int n;
		logic seen;
		n = start;
		seen = 1'b0;
		while (!seen && n < VALID_TIMEOUT) begin
			if (tf_valid === 1'b1) begin
				seen = 1'b1;
			end else begin
				@(negedge clk);
				n++;
			end
		end
		if (!seen) begin
			$display("tf_valid did not rise within %0d cycles after a step", VALID_TIMEOUT);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
		cycles = n;
	endtask

	task automatic drive_cmd(input tf_cmd_t c);
		@(negedge clk);
		cmd = c;
	endtask

	task automatic go_idle();
		drive_cmd(make_cmd(op_idle, '0, '0));
	endtask

	task automatic load_base(input tf_depth_t d, input tf_lane_vec_t row);
		@(negedge clk);
		base_in = row;
		cmd = make_cmd(op_load_base, d, '0);
		shadow_base[d] = row;
		go_idle();
	endtask

	task automatic load_consts(input tf_const_vec_t v);
		@(negedge clk);
		const_in = v;
		cmd = make_cmd(op_load_const, '0, '0);
		shadow_const = v;
		go_idle();
	endtask

	task automatic run_step(input tf_depth_t d, input tf_cidx_vec_t ci, input string what,
		output tf_lane_vec_t got);
		tf_lane_vec_t exp;
		int lat;
		exp = model_step(d, ci);
		drive_cmd(make_cmd(op_step, d, ci));
		go_idle();
		wait_valid(1, lat);
		check_latency(lat, STEP_LATENCY, what);
		check_lanes(tf_out, exp, what);
		got = tf_out;
		@(negedge clk);
		check_valid(tf_valid, 1'b0, {what, " single cycle pulse"});
	endtask

	// One step per depth on consecutive cycles
	task automatic pipelined_steps(input tf_cidx_vec_t [`TF_DEPTHS-1:0] ci_all,
		input string what);
		tf_lane_vec_t exp [`TF_DEPTHS];
		int lat;
		for (int d = 0; d < `TF_DEPTHS; d++) begin
			exp[d] = model_step(tf_depth_t'(d), ci_all[d]);
		end
		for (int d = 0; d < `TF_DEPTHS; d++) begin
			drive_cmd(make_cmd(op_step, tf_depth_t'(d), ci_all[d]));
		end
		go_idle();
		wait_valid(`TF_DEPTHS, lat);
		check_latency(lat, STEP_LATENCY, what);
		for (int d = 0; d < `TF_DEPTHS; d++) begin
			check_valid(tf_valid, 1'b1, $sformatf("%s, result %0d", what, d));
			check_lanes(tf_out, exp[d], $sformatf("%s, result %0d", what, d));
			@(negedge clk);
		end
		check_valid(tf_valid, 1'b0, {what, " after last result"});
	endtask

	task automatic test_after_reset();
		tf_lane_vec_t got;
		repeat (8) begin
			@(negedge clk);
			check_valid(tf_valid, 1'b0, "idle after reset");
		end
		run_step(2, {3'd1, 3'd2, 3'd3, 3'd4}, "step on unloaded row", got);
		check_lanes(got, '0, "unloaded row gives zero");
	endtask

	task automatic test_single_step();
		tf_const_vec_t cv;
		tf_lane_vec_t row;
		tf_lane_vec_t exp;
		tf_lane_vec_t got;
		tf_cidx_vec_t ci;
		for (int i = 0; i < `TF_CONSTS; i++) begin
			cv[i] = tf_word_t'(17 + 411 * i);
		end
		row = {12'd5, 12'd1000, 12'd3328, 12'd1};
		ci = {3'd7, 3'd2, 3'd5, 3'd0};
		load_consts(cv);
		load_base(1, row);
		for (int i = 0; i < `TF_LANES; i++) begin
			exp[i] = mod_mul(row[i], cv[ci[i]]);
		end
		run_step(1, ci, "single step", got);
		check_lanes(got, exp, "single step against base times constant");
	endtask

	task automatic test_write_back();
		tf_lane_vec_t row;
		tf_lane_vec_t exp;
		tf_lane_vec_t got;
		tf_cidx_vec_t ci;
		row = {12'd3000, 12'd2, 12'd1234, 12'd3327};
		ci = {3'd1, 3'd6, 3'd3, 3'd4};
		load_base(3, row);
		for (int k = 1; k <= 6; k++) begin
			run_step(3, ci, $sformatf("write-back step %0d", k), got);
			for (int i = 0; i < `TF_LANES; i++) begin
				exp[i] = mod_mul(row[i], pow_mod(shadow_const[ci[i]], k));
			end
			check_lanes(got, exp, $sformatf("base times constant to the power %0d", k));
		end
	endtask

	task automatic test_pipelining();
		tf_cidx_vec_t [`TF_DEPTHS-1:0] ci_all;
		for (int d = 0; d < `TF_DEPTHS; d++) begin
			load_base(tf_depth_t'(d), {12'd100 + 12'(d), 12'd2500, 12'd7 * 12'(d + 1), 12'd3328});
		end
		ci_all[0] = {3'd0, 3'd1, 3'd2, 3'd3};
		ci_all[1] = {3'd4, 3'd5, 3'd6, 3'd7};
		ci_all[2] = {3'd7, 3'd7, 3'd0, 3'd0};
		ci_all[3] = {3'd3, 3'd6, 3'd1, 3'd4};
		pipelined_steps(ci_all, "pipelined steps");
	endtask

	task automatic test_lane_select();
		tf_cidx_vec_t cases [5];
		tf_lane_vec_t got;
		cases[0] = {3'd0, 3'd0, 3'd0, 3'd0};
		cases[1] = {3'd7, 3'd7, 3'd7, 3'd7};
		cases[2] = {3'd0, 3'd7, 3'd3, 3'd5};
		cases[3] = {3'd6, 3'd1, 3'd4, 3'd2};
		cases[4] = {3'd7, 3'd0, 3'd7, 3'd0};
		load_consts({12'd3328, 12'd2900, 12'd2048, 12'd1500, 12'd999, 12'd512, 12'd33, 12'd2});
		for (int c = 0; c < 5; c++) begin
			load_base(0, {12'd2, 12'd3, 12'd4, 12'd5}); // Fresh row so the index alone decides
			run_step(0, cases[c], $sformatf("lane selection case %0d", c), got);
		end
	endtask

	task automatic test_random();
		tf_depth_t d;
		tf_lane_vec_t got;
		tf_cidx_vec_t [`TF_DEPTHS-1:0] ci_all;
		load_consts(rand_consts());
		for (int it = 0; it < 40; it++) begin
			if (rand_bits(2) == 32'd0)
				load_consts(rand_consts());
			d = tf_depth_t'(rand_bits($bits(tf_depth_t)));
			if (rand_bits(1) == 32'd1)
				load_base(d, rand_row());
			run_step(d, rand_cidx(), $sformatf("random step %0d", it), got);
		end
		for (int b = 0; b < 4; b++) begin
			for (int k = 0; k < `TF_DEPTHS; k++) begin
				load_base(tf_depth_t'(k), rand_row());
				ci_all[k] = rand_cidx();
			end
			pipelined_steps(ci_all, $sformatf("random burst %0d", b));
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cmd = make_cmd(op_idle, '0, '0);
		base_in = '0;
		const_in = '0;
		lfsr_state = 32'h328ffc11;
		shadow_const = '0;
		for (int d = 0; d < `TF_DEPTHS; d++) begin
			shadow_base[d] = '0; // Tables come out of reset cleared
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;
		test_after_reset();
		test_single_step();
		test_write_back();
		test_pipelining();
		test_lane_select();
		test_random();
		@(negedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
tf_arith_pkg.sv
tf_ctrl_pkg.sv
barrett_mult.sv
tf_base_bank.sv
tf_const_bank.sv
tf_step_ctrl.sv
tf_gen.sv
tf_gen_tb_assertions.sv
tf_gen_tb.sv

// File: Makefile
# Verilator build and run of the twiddle-factor generator testbench

VERILATOR ?= verilator
TOP       ?= tf_gen_tb
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

# The simulation exit status is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
